/* hdl/exe_config.svh */
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// datapath width
`define EXE_XLEN 32

// architectural register index
`define EXE_REG_AW 5

// operand half used by the split multiplier
`define EXE_HALF_W 16

`endif

/* hdl/exe_pkg.sv */
`include "exe_config.svh"

package exe_pkg;

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_slt   = 4'd2,
        op_sltu  = 4'd3,
        op_and   = 4'd4,
        op_or    = 4'd5,
        op_xor   = 4'd6,
        op_nor   = 4'd7,
        op_sll   = 4'd8,
        op_srl   = 4'd9,
        op_sra   = 4'd10,
        op_mul   = 4'd11,
        op_mulh  = 4'd12,
        op_mulhu = 4'd13
    } alu_op_e;

    // decoded operation from issue
    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        logic [`EXE_REG_AW-1:0] rd;
        logic [`EXE_REG_AW-1:0] rj;
        logic [`EXE_REG_AW-1:0] rk;
        logic [`EXE_XLEN-1:0]   imm;
        logic                   use_imm;
    } issue_t;

    // first stage to second stage
    typedef struct packed {
        logic                   valid;
        logic [`EXE_REG_AW-1:0] rd;
        logic                   is_mul;
        logic                   hi_sel;
        logic [`EXE_XLEN-1:0]   alu_res;
        logic [`EXE_XLEN-1:0]   pp_hh;
        logic [`EXE_XLEN-1:0]   pp_hl;
        logic [`EXE_XLEN-1:0]   pp_lh;
        logic [`EXE_XLEN-1:0]   pp_ll;
        logic [`EXE_XLEN-1:0]   corr;
    } mid_t;

    typedef struct packed {
        logic                   valid;
        logic [`EXE_REG_AW-1:0] rd;
        logic [`EXE_XLEN-1:0]   data;
    } wb_t;

endpackage

/* hdl/exe_issue_stage.sv */
`timescale 1ns/100ps
`include "exe_config.svh"

module exe_issue_stage (
    input  exe_pkg::issue_t        issue,
    input  logic [`EXE_XLEN-1:0]   rj_data,
    input  logic [`EXE_XLEN-1:0]   rk_data,
    input  exe_pkg::wb_t           fwd_mid,
    input  exe_pkg::wb_t           fwd_wb,
    input  logic                   mid_is_mul,
    input  logic [`EXE_REG_AW-1:0] mid_rd,
    input  logic                   wb_stall,
    output logic                   issue_stall,
    output exe_pkg::mid_t          mid_next
);

    logic [`EXE_XLEN-1:0]   src_j;
    logic [`EXE_XLEN-1:0]   src_k;
    logic [`EXE_XLEN-1:0]   opa;
    logic [`EXE_XLEN-1:0]   opb;
    logic [4:0]             shamt;
    logic [`EXE_XLEN-1:0]   alu_res;
    logic                   is_mul;
    logic                   rj_hit;
    logic                   rk_hit;
    logic                   mul_hazard;
    logic [`EXE_HALF_W-1:0] a_hi;
    logic [`EXE_HALF_W-1:0] a_lo;
    logic [`EXE_HALF_W-1:0] b_hi;
    logic [`EXE_HALF_W-1:0] b_lo;
    logic [`EXE_XLEN-1:0]   corr_a;
    logic [`EXE_XLEN-1:0]   corr_b;

    // newest producer wins, r0 never forwarded
    function automatic logic [`EXE_XLEN-1:0] pick_src(
        input logic [`EXE_REG_AW-1:0] addr,
        input logic [`EXE_XLEN-1:0]   rf_val,
        input exe_pkg::wb_t           near,
        input exe_pkg::wb_t           far
    );
        logic [`EXE_XLEN-1:0] val;
        val = rf_val;
        if (addr != '0) begin
            if (near.valid && near.rd == addr) begin
                val = near.data;
            end else if (far.valid && far.rd == addr) begin
                val = far.data;
            end
        end
        return val;
    endfunction

    assign src_j = pick_src(issue.rj, rj_data, fwd_mid, fwd_wb);
    assign src_k = pick_src(issue.rk, rk_data, fwd_mid, fwd_wb);

    assign opa   = src_j;
    assign opb   = issue.use_imm ? issue.imm : src_k;
    assign shamt = opb[4:0];

    assign is_mul = issue.op == exe_pkg::op_mul
                 || issue.op == exe_pkg::op_mulh
                 || issue.op == exe_pkg::op_mulhu;

    // multiply result not ready until the finish stage
    assign rj_hit     = mid_rd == issue.rj;
    assign rk_hit     = !issue.use_imm && mid_rd == issue.rk;
    assign mul_hazard = issue.valid && mid_is_mul && mid_rd != '0 && (rj_hit || rk_hit);

    assign issue_stall = wb_stall || mul_hazard;

    always_comb begin
        case (issue.op)
            exe_pkg::op_add:  alu_res = opa + opb;
            exe_pkg::op_sub:  alu_res = opa - opb;
            exe_pkg::op_slt:  alu_res = {{(`EXE_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            exe_pkg::op_sltu: alu_res = {{(`EXE_XLEN-1){1'b0}}, opa < opb};
            exe_pkg::op_and:  alu_res = opa & opb;
            exe_pkg::op_or:   alu_res = opa | opb;
            exe_pkg::op_xor:  alu_res = opa ^ opb;
            exe_pkg::op_nor:  alu_res = ~(opa | opb);
            exe_pkg::op_sll:  alu_res = opa << shamt;
            exe_pkg::op_srl:  alu_res = opa >> shamt;
            exe_pkg::op_sra:  alu_res = $unsigned($signed(opa) >>> shamt);
            default:          alu_res = '0;
        endcase
    end

    assign a_hi = opa[`EXE_XLEN-1:`EXE_HALF_W];
    assign a_lo = opa[`EXE_HALF_W-1:0];
    assign b_hi = opb[`EXE_XLEN-1:`EXE_HALF_W];
    assign b_lo = opb[`EXE_HALF_W-1:0];

    // signed high word = unsigned high word - (a<0 ? b : 0) - (b<0 ? a : 0)
    assign corr_a = opa[`EXE_XLEN-1] ? opb : '0;
    assign corr_b = opb[`EXE_XLEN-1] ? opa : '0;

    always_comb begin
        mid_next         = '0;
        // register zeroes the payload on a hazard bubble
        mid_next.valid   = issue.valid && !issue_stall;
        mid_next.rd      = issue.rd;
        mid_next.is_mul  = is_mul;
        mid_next.hi_sel  = is_mul && issue.op != exe_pkg::op_mul;
        mid_next.alu_res = alu_res;
        mid_next.pp_hh   = a_hi * b_hi;
        mid_next.pp_hl   = a_hi * b_lo;
        mid_next.pp_lh   = a_lo * b_hi;
        mid_next.pp_ll   = a_lo * b_lo;
        if (issue.op == exe_pkg::op_mulh) begin
            mid_next.corr = '0 - corr_a - corr_b;
        end
    end

endmodule

/* hdl/exe_stage_reg.sv */
`timescale 1ns/100ps

module exe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // hold wins over bubble so a stalled entry is never dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (!hold) begin
            if (bubble) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

/* hdl/exe_finish_stage.sv */
`timescale 1ns/100ps
`include "exe_config.svh"

module exe_finish_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  exe_pkg::mid_t          mid,
    input  logic                   wb_ready,
    output exe_pkg::wb_t           wb,
    output logic                   wb_stall,
    output exe_pkg::wb_t           fwd_mid,
    output exe_pkg::wb_t           fwd_wb,
    output logic                   mid_is_mul,
    output logic [`EXE_REG_AW-1:0] mid_rd
);

    localparam int P_W = 2 * `EXE_XLEN;

    logic [P_W-1:0]       prod;
    logic [`EXE_XLEN-1:0] prod_hi;
    logic [`EXE_XLEN-1:0] result;
    exe_pkg::wb_t         wb_next;

    // partial products back into the full 64-bit product
    assign prod = P_W'(mid.pp_ll)
                + (P_W'(mid.pp_lh) << `EXE_HALF_W)
                + (P_W'(mid.pp_hl) << `EXE_HALF_W)
                + (P_W'(mid.pp_hh) << `EXE_XLEN);

    // corr is zero except for mulh
    assign prod_hi = prod[P_W-1:`EXE_XLEN] + mid.corr;

    always_comb begin
        if (!mid.is_mul) begin
            result = mid.alu_res;
        end else if (mid.hi_sel) begin
            result = prod_hi;
        end else begin
            result = prod[`EXE_XLEN-1:0];
        end
    end

    assign wb_next.valid = mid.valid;
    assign wb_next.rd    = mid.rd;
    assign wb_next.data  = result;

    assign wb_stall = wb.valid && !wb_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else if (!wb_stall) begin
            wb <= wb_next;
        end
    end

    // multiply product is not known yet in mid
    assign fwd_mid.valid = mid.valid && !mid.is_mul;
    assign fwd_mid.rd    = mid.rd;
    assign fwd_mid.data  = mid.alu_res;

    assign fwd_wb = wb;

    assign mid_is_mul = mid.valid && mid.is_mul;
    assign mid_rd     = mid.rd;

endmodule

/* hdl/exe_pipe.sv */
`timescale 1ns/100ps
`include "exe_config.svh"

module exe_pipe (
    input  logic                 clk,
    input  logic                 arst_n,
    input  exe_pkg::issue_t      issue,
    input  logic [`EXE_XLEN-1:0] rj_data,
    input  logic [`EXE_XLEN-1:0] rk_data,
    input  logic                 wb_ready,
    output logic                 issue_stall,
    output exe_pkg::wb_t         wb
);

    exe_pkg::mid_t          mid_next;
    exe_pkg::mid_t          mid_q;
    exe_pkg::wb_t           fwd_mid;
    exe_pkg::wb_t           fwd_wb;
    logic                   mid_is_mul;
    logic [`EXE_REG_AW-1:0] mid_rd;
    logic                   wb_stall;

    // forwarding, ALU and multiply partial products
    exe_issue_stage u_issue (
        .issue       (issue),
        .rj_data     (rj_data),
        .rk_data     (rk_data),
        .fwd_mid     (fwd_mid),
        .fwd_wb      (fwd_wb),
        .mid_is_mul  (mid_is_mul),
        .mid_rd      (mid_rd),
        .wb_stall    (wb_stall),
        .issue_stall (issue_stall),
        .mid_next    (mid_next)
    );

    // holds on writeback back-pressure, bubbles on a multiply hazard
    exe_stage_reg #(
        .payload_t (exe_pkg::mid_t)
    ) mid_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (wb_stall),
        .bubble (issue_stall),
        .d      (mid_next),
        .q      (mid_q)
    );

    // product sum and writeback register
    exe_finish_stage u_finish (
        .clk        (clk),
        .arst_n     (arst_n),
        .mid        (mid_q),
        .wb_ready   (wb_ready),
        .wb         (wb),
        .wb_stall   (wb_stall),
        .fwd_mid    (fwd_mid),
        .fwd_wb     (fwd_wb),
        .mid_is_mul (mid_is_mul),
        .mid_rd     (mid_rd)
    );

endmodule

/* verification/exe_properties.sv */
`timescale 1ns/100ps

module exe_properties (
    input logic         clk,
    input logic         arst_n,
    input exe_pkg::wb_t wb,
    input logic         wb_ready,
    input logic         issue_stall
);

    // writeback record frozen under back-pressure
    wb_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb.valid && !wb_ready |=> $stable(wb)
    ) else $error("wb changed while valid and not ready");

    // issue must see the writeback stall
    stall_seen: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb.valid && !wb_ready |-> issue_stall
    ) else $error("issue_stall low during writeback stall");

    wb_idle_after_reset: assert property (
        @(posedge clk)
        $rose(arst_n) |-> !wb.valid
    ) else $error("wb.valid high in first cycle after reset");

endmodule

bind exe_pipe exe_properties u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb          (wb),
    .wb_ready    (wb_ready),
    .issue_stall (issue_stall)
);

/* verification/exe_tb.sv */
`timescale 1ns/100ps
`include "exe_config.svh"

module exe_tb;

    localparam int N_OPS      = 400;
    localparam int MAX_CYCLES = 4 * N_OPS + 100;

    typedef struct packed {
        logic [`EXE_REG_AW-1:0] rd;
        logic [`EXE_XLEN-1:0]   data;
        int                     acc_cycle;
    } expect_t;

    logic                 clk;
    logic                 arst_n;
    exe_pkg::issue_t      issue;
    logic [`EXE_XLEN-1:0] rj_data;
    logic [`EXE_XLEN-1:0] rk_data;
    logic                 wb_ready;
    logic                 issue_stall;
    exe_pkg::wb_t         wb;

    // arch_rf follows writeback and prog_rf follows issue order
    logic [`EXE_XLEN-1:0]   arch_rf [2**`EXE_REG_AW];
    logic [`EXE_XLEN-1:0]   prog_rf [2**`EXE_REG_AW];
    expect_t                exp_q [$];
    logic [31:0]            lcg_state;
    int                     cycle;
    int                     last_stall;
    int                     presented;
    int                     accepted;
    int                     retired;
    int                     low_left;
    logic                   took;
    logic                   exp_mid_mul;
    logic [`EXE_REG_AW-1:0] exp_mid_rd;
    logic                   wb_was_held;
    exe_pkg::wb_t           held_wb;

    exe_pipe dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .rj_data     (rj_data),
        .rk_data     (rk_data),
        .wb_ready    (wb_ready),
        .issue_stall (issue_stall),
        .wb          (wb)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // low LCG bits repeat quickly so only the upper half is used
    function automatic logic [31:0] rand16();
        lcg_state = lcg_next(lcg_state);
        return {16'd0, lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand16();
        lo = rand16();
        return {hi[15:0], lo[15:0]};
    endfunction

    function automatic logic [`EXE_XLEN-1:0] ref_exec(
        input exe_pkg::alu_op_e     op,
        input logic [`EXE_XLEN-1:0] a,
        input logic [`EXE_XLEN-1:0] b
    );
        logic [63:0]        pu;
        logic signed [63:0] ps;
        logic [4:0]         sh;
        logic [31:0]        res;
        pu = {32'd0, a} * {32'd0, b};
        ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        sh = b[4:0];
        case (op)
            exe_pkg::op_add:   res = a + b;
            exe_pkg::op_sub:   res = a - b;
            exe_pkg::op_slt:   res = {31'd0, $signed(a) < $signed(b)};
            exe_pkg::op_sltu:  res = {31'd0, a < b};
            exe_pkg::op_and:   res = a & b;
            exe_pkg::op_or:    res = a | b;
            exe_pkg::op_xor:   res = a ^ b;
            exe_pkg::op_nor:   res = ~(a | b);
            exe_pkg::op_sll:   res = a << sh;
            exe_pkg::op_srl:   res = a >> sh;
            exe_pkg::op_sra:   res = $signed(a) >>> sh;
            exe_pkg::op_mul:   res = pu[31:0];
            exe_pkg::op_mulh:  res = ps[63:32];
            exe_pkg::op_mulhu: res = pu[63:32];
            default:           res = '0;
        endcase
        return res;
    endfunction

    task automatic stop_failed();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
        $display("Fail time=%0t signal=%s expected=0x%h got=0x%h", $time, name, exp, got);
        stop_failed();
    endtask

    task automatic report_error(input string what);
        $display("Error at time %0t: %s", $time, what);
        stop_failed();
    endtask

    task automatic make_op(output exe_pkg::issue_t op);
        logic [31:0] r;
        op       = '0;
        op.valid = 1'b1;
        r        = rand16();
        op.op    = exe_pkg::alu_op_e'(4'(r % 14));
        // small register pool keeps dependencies dense
        r        = rand16();
        op.rd    = `EXE_REG_AW'(r % 4);
        r        = rand16();
        op.rj    = `EXE_REG_AW'(r % 4);
        r        = rand16();
        op.rk    = `EXE_REG_AW'(r % 4);
        r        = rand16();
        op.use_imm = r[15];
        r = rand16();
        case (r % 8)
            0:       op.imm = 32'h8000_0000;
            1:       op.imm = 32'hffff_ffff;
            2:       op.imm = 32'h7fff_ffff;
            3:       op.imm = (r / 8) % 32;
            default: op.imm = rand_word();
        endcase
    endtask

    task automatic drive_step();
        logic [31:0] r;
        if (took || !issue.valid) begin
            took = 1'b0;
            r = rand16();
            if (presented < N_OPS && r % 8 != 0) begin
                make_op(issue);
                presented++;
            end else begin
                issue = '0;
            end
        end
        // first half runs with writeback always ready
        if (presented <= N_OPS / 2) begin
            wb_ready = 1'b1;
        end else if (low_left > 0) begin
            wb_ready = 1'b0;
            low_left--;
        end else begin
            r = rand16();
            if (r % 6 == 0) begin
                wb_ready = 1'b0;
                low_left = int'((r / 6) % 3);
            end else begin
                wb_ready = 1'b1;
            end
        end
        rj_data = arch_rf[issue.rj];
        rk_data = arch_rf[issue.rk];
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            cycle <= cycle + 1;
            if (cycle >= MAX_CYCLES) begin
                report_error($sformatf("timeout after %0d cycles with %0d of %0d results retired",
                                       cycle, retired, N_OPS));
            end
        end
    end

    // expected stall and expected result of each accepted operation
    always @(posedge clk) begin
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic        wb_blocked;
        logic        hazard;
        logic        stall_exp;
        if (arst_n) begin
            wb_blocked = wb.valid && !wb_ready;
            hazard     = issue.valid && exp_mid_mul && exp_mid_rd != '0
                      && (exp_mid_rd == issue.rj
                          || (!issue.use_imm && exp_mid_rd == issue.rk));
            stall_exp  = wb_blocked || hazard;
            assert (issue_stall == stall_exp)
            else value_mismatch("issue_stall", 32'(stall_exp), 32'(issue_stall));
            // mid stage holds under back-pressure and takes a bubble on a stall
            if (!wb_blocked) begin
                exp_mid_mul = issue.valid && !stall_exp
                           && issue.op inside {exe_pkg::op_mul, exe_pkg::op_mulh,
                                               exe_pkg::op_mulhu};
                exp_mid_rd  = issue.rd;
            end
            if (issue.valid && !issue_stall) begin
                a           = prog_rf[issue.rj];
                b           = issue.use_imm ? issue.imm : prog_rf[issue.rk];
                e.rd        = issue.rd;
                e.data      = ref_exec(issue.op, a, b);
                e.acc_cycle = cycle;
                exp_q.push_back(e);
                if (issue.rd != '0) begin
                    prog_rf[issue.rd] = e.data;
                end
                accepted++;
                took = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        expect_t e;
        int      lat;
        if (arst_n) begin
            if (cycle == 0) begin
                assert (!wb.valid)
                else report_error("wb.valid high in the first cycle after reset");
            end
            // a stalled record must not move
            if (wb_was_held) begin
                assert (wb.valid)
                else report_error("wb.valid dropped while writeback was not ready");
                assert (wb.rd == held_wb.rd)
                else value_mismatch("held wb.rd", 32'(held_wb.rd), 32'(wb.rd));
                assert (wb.data == held_wb.data)
                else value_mismatch("held wb.data", held_wb.data, wb.data);
            end
            wb_was_held = wb.valid && !wb_ready;
            held_wb     = wb;
            if (wb.valid && !wb_ready) begin
                last_stall = cycle;
            end
            if (wb.valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("writeback delivered a result with no operation outstanding");
                end else begin
                    e   = exp_q.pop_front();
                    lat = cycle - e.acc_cycle;
                    assert (wb.rd == e.rd)
                    else value_mismatch("wb.rd", 32'(e.rd), 32'(wb.rd));
                    assert (wb.data == e.data)
                    else value_mismatch("wb.data", e.data, wb.data);
                    // no back-pressure since acceptance
                    if (last_stall < e.acc_cycle) begin
                        assert (lat == 2)
                        else value_mismatch("wb latency", 32'd2, 32'(lat));
                    end
                    if (wb.rd != '0) begin
                        arch_rf[wb.rd] = wb.data;
                    end
                    retired++;
                end
            end
        end
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        issue       = '0;
        rj_data     = '0;
        rk_data     = '0;
        wb_ready    = 1'b1;
        lcg_state   = 32'h4893_ac03;
        cycle       = 0;
        last_stall  = -1;
        presented   = 0;
        accepted    = 0;
        retired     = 0;
        low_left    = 0;
        took        = 1'b0;
        exp_mid_mul = 1'b0;
        exp_mid_rd  = '0;
        wb_was_held = 1'b0;
        held_wb     = '0;
        for (int i = 0; i < 2**`EXE_REG_AW; i++) begin
            arch_rf[i] = '0;
        end
        arch_rf[1] = 32'h8000_0000;
        arch_rf[2] = 32'hffff_ffff;
        arch_rf[3] = rand_word();
        prog_rf    = arch_rf;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        while (retired < N_OPS) begin
            drive_step();
            @(negedge clk);
        end

        // idle tail to catch a repeated result
        issue    = '0;
        wb_ready = 1'b1;
        repeat (8) @(negedge clk);

        if (accepted == N_OPS && exp_q.size() == 0 && !wb.valid) begin
            $display("Verification passed");
            $finish;
        end else begin
            report_error($sformatf("run ended with %0d accepted, %0d retired, %0d pending",
                                   accepted, retired, exp_q.size()));
        end
    end

endmodule

/* exe.f */
+incdir+hdl
hdl/exe_pkg.sv
hdl/exe_issue_stage.sv
hdl/exe_stage_reg.sv
hdl/exe_finish_stage.sv
hdl/exe_pipe.sv
verification/exe_properties.sv
verification/exe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exe_tb
FILELIST  ?= exe.f
MDIR      ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)
	./$(MDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
